/* hdl/aesBlockPkg.sv */
/*
  AES block data types
  bytes, columns and the 128-bit state seen as bytes or as words
*/
`include "aes_defines.svh"

package aesBlockPkg;

  // one state byte
  typedef logic [7:0] aesByte;
  // one column, row 0 in the top byte
  typedef logic [31:0] aesWord;

  // b[0] sits at bits 127:120, b[4*c+r] is row r of column c
  // w[0] is the leftmost column, w[c] holds b[4*c] to b[4*c+3]
  typedef union packed {
    aesByte [0:`AES_BLOCK_BITS/8-1] b;
    aesWord [0:`AES_NB-1]           w;
  } aesBlock;

  // multiply by x modulo the AES polynomial
  function automatic aesByte gfDouble(aesByte a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // general GF(2^8) product, shift and add
  function automatic aesByte gfMul(aesByte a, aesByte b);
    aesByte acc;
    aesByte x;
    acc = '0;
    x   = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) acc = acc ^ x;
      x = gfDouble(x);
    end
    return acc;
  endfunction

endpackage

/* hdl/aesCore.sv */
/*
  AES-128 block engine top level
  one block per request, round keys generated on the fly
*/
`timescale 1ns/1ps

module aesCore (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 reqValid,
  output logic                 reqReady,
  input  aesCtrlPkg::aesReq    req,
  output logic                 respValid,
  input  logic                 respReady,
  output aesBlockPkg::aesBlock resp
);

  aesCtrlPkg::aesKeyOp     keyOp;
  aesBlockPkg::aesBlock    keyIn;
  aesBlockPkg::aesBlock    roundKey;
  aesBlockPkg::aesBlock    roundIn;
  aesBlockPkg::aesBlock    roundOut;
  aesCtrlPkg::aesRoundKind roundKind;
  logic                    decrypt;

  // handshake, counter and state register
  aesSequencer seq (
    .clk      (clk),
    .arstN    (arstN),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .req      (req),
    .respValid(respValid),
    .respReady(respReady),
    .resp     (resp),
    .keyOp    (keyOp),
    .keyIn    (keyIn),
    .roundIn  (roundIn),
    .roundKind(roundKind),
    .decrypt  (decrypt),
    .roundOut (roundOut)
  );

  // round key, stepped in the same edge as the state
  aesKeySchedule keySched (
    .clk     (clk),
    .arstN   (arstN),
    .keyOp   (keyOp),
    .keyIn   (keyIn),
    .roundKey(roundKey)
  );

  // one cipher round per cycle
  aesRound round (
    .roundIn  (roundIn),
    .roundKey (roundKey),
    .roundKind(roundKind),
    .decrypt  (decrypt),
    .roundOut (roundOut)
  );

endmodule

/* hdl/aesCtrlPkg.sv */
/*
  AES engine control types
  request payload, round kind and key register operation
*/
package aesCtrlPkg;

  // one request, key and data travel together with the direction
  typedef struct packed {
    aesBlockPkg::aesBlock key;
    aesBlockPkg::aesBlock data;
    logic                 decrypt;
  } aesReq;

  // initial is AddRoundKey only, final skips the column mixing
  typedef enum logic [1:0] {
    kindInitial,
    kindMiddle,
    kindFinal
  } aesRoundKind;

  // what the key register does on the next edge
  typedef enum logic [1:0] {
    keyHold,
    keyLoad,
    keyForward,
    keyBackward
  } aesKeyOp;

endpackage

/* hdl/aesKeySchedule.sv */
/*
  AES-128 on-the-fly round key register
  steps one round key forward or backward per cycle, with its own Rcon
*/
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesKeySchedule (
  input  logic                 clk,
  input  logic                 arstN,
  input  aesCtrlPkg::aesKeyOp  keyOp,
  input  aesBlockPkg::aesBlock keyIn,
  output aesBlockPkg::aesBlock roundKey
);

  aesBlockPkg::aesBlock keyQ;
  aesBlockPkg::aesBlock nextKey;
  aesBlockPkg::aesBlock prevKey;
  aesBlockPkg::aesByte  rconQ;
  aesBlockPkg::aesByte  halfRcon;
  aesBlockPkg::aesWord  lastWord;
  aesBlockPkg::aesWord  rotWord;
  aesBlockPkg::aesWord  subWord;
  aesBlockPkg::aesByte  subOut [4];

  // divide by x, inverse of gfDouble
  function automatic aesBlockPkg::aesByte gfHalf(aesBlockPkg::aesByte a);
    return a[0] ? (((a ^ 8'h1b) >> 1) | 8'h80) : (a >> 1);
  endfunction

  // going back, the old last word is w3 ^ w2 of the current key
  assign lastWord = (keyOp == aesCtrlPkg::keyBackward) ?
                    (keyQ.w[`AES_NB-1] ^ keyQ.w[`AES_NB-2]) : keyQ.w[`AES_NB-1];

  // RotWord, one byte left
  assign rotWord = {lastWord[23:0], lastWord[31:24]};

  // SubWord on the rotated word
  for (genvar i = 0; i < 4; i++) begin : gSbox
    aesSbox sbox (
      .in    (rotWord[31-8*i -: 8]),
      .sub   (subOut[i]),
      .invSub()
    );
  end

  assign subWord  = {subOut[0], subOut[1], subOut[2], subOut[3]};
  assign halfRcon = gfHalf(rconQ);
  assign roundKey = keyQ;

  always_comb begin
    // forward: each word chains off the new word to its left
    nextKey.w[0] = keyQ.w[0] ^ subWord ^ {rconQ, 24'h0};
    for (int i = 1; i < `AES_NB; i++) begin
      nextKey.w[i] = nextKey.w[i-1] ^ keyQ.w[i];
    end
    // backward: neighbours of the current key give words 1..3
    prevKey.w[0] = keyQ.w[0] ^ subWord ^ {halfRcon, 24'h0};
    for (int i = 1; i < `AES_NB; i++) begin
      prevKey.w[i] = keyQ.w[i] ^ keyQ.w[i-1];
    end
  end

  // round constant, halved before use when stepping back
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rconQ <= 8'h01;
    end else begin
      case (keyOp)
        aesCtrlPkg::keyLoad:     rconQ <= 8'h01;
        aesCtrlPkg::keyForward:  rconQ <= aesBlockPkg::gfDouble(rconQ);
        aesCtrlPkg::keyBackward: rconQ <= halfRcon;
        default:                 rconQ <= rconQ;
      endcase
    end
  end

  // key word storage
  always_ff @(posedge clk) begin
    case (keyOp)
      aesCtrlPkg::keyLoad:     keyQ <= keyIn;
      aesCtrlPkg::keyForward:  keyQ <= nextKey;
      aesCtrlPkg::keyBackward: keyQ <= prevKey;
      default:                 keyQ <= keyQ;
    endcase
  end

endmodule

/* hdl/aesRound.sv */
/*
  one AES round, encrypt or decrypt, purely combinational
  round kind picks AddRoundKey only, full round or last round
*/
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesRound (
  input  aesBlockPkg::aesBlock   roundIn,
  input  aesBlockPkg::aesBlock   roundKey,
  input  aesCtrlPkg::aesRoundKind roundKind,
  input  logic                   decrypt,
  output aesBlockPkg::aesBlock   roundOut
);

  localparam int NumBytes = 4 * `AES_NB;

  aesBlockPkg::aesByte  subByte    [NumBytes];
  aesBlockPkg::aesByte  invSubByte [NumBytes];
  aesBlockPkg::aesBlock shifted;
  aesBlockPkg::aesBlock invShifted;
  aesBlockPkg::aesBlock mixed;
  aesBlockPkg::aesBlock decKeyed;
  aesBlockPkg::aesBlock invMixed;
  aesBlockPkg::aesBlock encOut;
  aesBlockPkg::aesBlock decOut;

  // circulant column product, coef holds the first matrix row
  function automatic aesBlockPkg::aesWord mixWith(aesBlockPkg::aesWord col,
                                                  aesBlockPkg::aesWord coef);
    aesBlockPkg::aesWord res;
    res = '0;
    for (int r = 0; r < 4; r++) begin
      for (int j = 0; j < 4; j++) begin
        res[31-8*r -: 8] = res[31-8*r -: 8] ^
            aesBlockPkg::gfMul(col[31-8*j -: 8], coef[31-8*((j-r+4)%4) -: 8]);
      end
    end
    return res;
  endfunction

  // SubBytes and InvSubBytes are bytewise, so they run ahead of the row shift
  for (genvar i = 0; i < NumBytes; i++) begin : gSbox
    aesSbox sbox (
      .in    (roundIn.b[i]),
      .sub   (subByte[i]),
      .invSub(invSubByte[i])
    );
  end

  always_comb begin
    // row r rotates left by r for encrypt, right by r for decrypt
    for (int c = 0; c < `AES_NB; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.b[4*c+r]    = subByte[4*((c+r)%`AES_NB)+r];
        invShifted.b[4*c+r] = invSubByte[4*((c-r+`AES_NB)%`AES_NB)+r];
      end
    end
  end

  // encrypt mixes before the key add
  always_comb begin
    for (int c = 0; c < `AES_NB; c++) begin
      mixed.w[c] = mixWith(shifted.w[c], 32'h02030101);
    end
  end

  assign encOut = ((roundKind == aesCtrlPkg::kindFinal) ? shifted : mixed) ^ roundKey;

  // decrypt adds the key, then unmixes
  assign decKeyed = invShifted ^ roundKey;

  always_comb begin
    for (int c = 0; c < `AES_NB; c++) begin
      invMixed.w[c] = mixWith(decKeyed.w[c], 32'h0e0b0d09);
    end
  end

  assign decOut = (roundKind == aesCtrlPkg::kindFinal) ? decKeyed : invMixed;

  // initial round is a plain key add in either direction
  always_comb begin
    if (roundKind == aesCtrlPkg::kindInitial) begin
      roundOut = roundIn ^ roundKey;
    end else if (decrypt) begin
      roundOut = decOut;
    end else begin
      roundOut = encOut;
    end
  end

endmodule

/* hdl/aesSbox.sv */
/*
  AES S-box, forward and inverse, computed from the field inverse
  no table, both directions come out together
*/
`timescale 1ns/1ps

module aesSbox (
  input  aesBlockPkg::aesByte in,
  output aesBlockPkg::aesByte sub,
  output aesBlockPkg::aesByte invSub
);

  aesBlockPkg::aesByte invIn;
  aesBlockPkg::aesByte preInv;

  // rotate a byte left by n
  function automatic aesBlockPkg::aesByte rotl(aesBlockPkg::aesByte a, int n);
    return (a << n) | (a >> (8 - n));
  endfunction

  // a^254, which is a^-1 for nonzero a and maps 0 to 0
  function automatic aesBlockPkg::aesByte gfInv(aesBlockPkg::aesByte a);
    aesBlockPkg::aesByte x2;
    aesBlockPkg::aesByte x3;
    aesBlockPkg::aesByte x12;
    aesBlockPkg::aesByte x15;
    aesBlockPkg::aesByte t;
    x2  = aesBlockPkg::gfMul(a, a);
    x3  = aesBlockPkg::gfMul(x2, a);
    x12 = aesBlockPkg::gfMul(x3, x3);
    x12 = aesBlockPkg::gfMul(x12, x12);
    x15 = aesBlockPkg::gfMul(x12, x3);
    // four squarings give x^240
    t = x15;
    for (int i = 0; i < 4; i++) begin
      t = aesBlockPkg::gfMul(t, t);
    end
    // 240 + 12 + 2
    t = aesBlockPkg::gfMul(t, x12);
    return aesBlockPkg::gfMul(t, x2);
  endfunction

  // forward affine map, b = a ^ rotations 1..4 ^ 0x63
  function automatic aesBlockPkg::aesByte affine(aesBlockPkg::aesByte a);
    return a ^ rotl(a, 1) ^ rotl(a, 2) ^ rotl(a, 3) ^ rotl(a, 4) ^ 8'h63;
  endfunction

  // inverse affine map, rotations 1, 3, 6 and constant 0x05
  function automatic aesBlockPkg::aesByte invAffine(aesBlockPkg::aesByte a);
    return rotl(a, 1) ^ rotl(a, 3) ^ rotl(a, 6) ^ 8'h05;
  endfunction

  // forward path: inverse then affine
  assign invIn  = gfInv(in);
  assign sub    = affine(invIn);

  // inverse path: undo the affine map, then invert
  assign preInv = invAffine(in);
  assign invSub = gfInv(preInv);

endmodule

/* hdl/aesSequencer.sv */
/*
  AES engine sequencer
  request/response handshake, round counter, state register, key control
*/
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesSequencer (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    reqValid,
  output logic                    reqReady,
  input  aesCtrlPkg::aesReq       req,
  output logic                    respValid,
  input  logic                    respReady,
  output aesBlockPkg::aesBlock    resp,
  output aesCtrlPkg::aesKeyOp     keyOp,
  output aesBlockPkg::aesBlock    keyIn,
  output aesBlockPkg::aesBlock    roundIn,
  output aesCtrlPkg::aesRoundKind roundKind,
  output logic                    decrypt,
  input  aesBlockPkg::aesBlock    roundOut
);

  localparam logic [3:0] lastRound  = 4'(`AES_ROUNDS);
  localparam logic [3:0] lastExpand = 4'(`AES_ROUNDS - 1);

  // expand only runs for decrypt, to reach the last round key
  typedef enum logic [1:0] {
    phaseIdle,
    phaseExpand,
    phaseRounds,
    phaseHold
  } seqPhase;

  seqPhase              phase;
  logic [3:0]           cnt;
  logic                 decryptQ;
  logic                 accept;
  aesBlockPkg::aesBlock stateQ;

  assign reqReady  = (phase == phaseIdle);
  assign accept    = reqValid && reqReady;
  assign respValid = (phase == phaseHold);
  assign resp      = stateQ;
  assign roundIn   = stateQ;
  assign decrypt   = decryptQ;
  // key goes straight in, loaded on the accepting edge
  assign keyIn     = req.key;

  // counter 0 is the initial add, lastRound the final round
  always_comb begin
    if (cnt == '0) begin
      roundKind = aesCtrlPkg::kindInitial;
    end else if (cnt == lastRound) begin
      roundKind = aesCtrlPkg::kindFinal;
    end else begin
      roundKind = aesCtrlPkg::kindMiddle;
    end
  end

  // key steps with every round except the last one
  always_comb begin
    keyOp = aesCtrlPkg::keyHold;
    case (phase)
      phaseIdle: begin
        if (accept) keyOp = aesCtrlPkg::keyLoad;
      end
      phaseExpand: begin
        keyOp = aesCtrlPkg::keyForward;
      end
      phaseRounds: begin
        if (cnt != lastRound) begin
          keyOp = decryptQ ? aesCtrlPkg::keyBackward : aesCtrlPkg::keyForward;
        end
      end
      default: begin
        keyOp = aesCtrlPkg::keyHold;
      end
    endcase
  end

  // phase and counter
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phase    <= phaseIdle;
      cnt      <= '0;
      decryptQ <= 1'b0;
    end else begin
      case (phase)
        phaseIdle: begin
          if (accept) begin
            cnt      <= '0;
            decryptQ <= req.decrypt;
            phase    <= req.decrypt ? phaseExpand : phaseRounds;
          end
        end
        phaseExpand: begin
          // ten forward steps, counter restarts for the rounds
          if (cnt == lastExpand) begin
            cnt   <= '0;
            phase <= phaseRounds;
          end else begin
            cnt <= cnt + 4'd1;
          end
        end
        phaseRounds: begin
          if (cnt == lastRound) begin
            phase <= phaseHold;
          end else begin
            cnt <= cnt + 4'd1;
          end
        end
        default: begin
          // result waits here under back-pressure
          if (respReady) phase <= phaseIdle;
        end
      endcase
    end
  end

  // state register, data at acceptance, then one round per cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      stateQ <= req.data;
    end else if (phase == phaseRounds) begin
      stateQ <= roundOut;
    end
  end

endmodule

/* hdl/aes_defines.svh */
/*
  AES-128 engine constants
  round count, block width and columns per block
*/
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// cipher rounds for a 128-bit key
`define AES_ROUNDS 10
// block and key width in bits
`define AES_BLOCK_BITS 128
// 32-bit columns per block
`define AES_NB 4

`endif

/* list.f */
+incdir+hdl
hdl/aesBlockPkg.sv
hdl/aesCtrlPkg.sv
hdl/aesSbox.sv
hdl/aesKeySchedule.sv
hdl/aesRound.sv
hdl/aesSequencer.sv
hdl/aesCore.sv
testbench/aesCoreTb.sv

/* testbench/aesCoreTb.sv */
/*
  self-checking testbench for the AES-128 block engine
  runs known-answer vectors, checks results, latency and back-pressure
*/
`timescale 1ns/1ps
`include "aes_defines.svh"

module aesCoreTb;

  // cycles from the accepting edge to respValid
  localparam int EncLatency = 11;
  localparam int DecLatency = 21;
  // worst case per vector is decrypt latency plus request gap plus response stall
  localparam int CyclesPerVector = DecLatency + 8 + 8;

  logic                 clk;
  logic                 arstN;
  logic                 reqValid;
  logic                 reqReady;
  aesCtrlPkg::aesReq    req;
  logic                 respValid;
  logic                 respReady;
  aesBlockPkg::aesBlock resp;

  // vectors from the data file
  bit                         vecDir [$];
  logic [`AES_BLOCK_BITS-1:0] vecKey [$];
  logic [`AES_BLOCK_BITS-1:0] vecIn  [$];
  logic [`AES_BLOCK_BITS-1:0] vecOut [$];

  integer seed;
  integer rnd;
  int     cycleCount = 0;
  int     cycleLimit = 0;
  int     valueErrors = 0;
  int     timingErrors = 0;
  int     handshakeErrors = 0;

  aesCore uut (
    .clk      (clk),
    .arstN    (arstN),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .req      (req),
    .respValid(respValid),
    .respReady(respReady),
    .resp     (resp)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog on the cycle count
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("TEST FAIL");
      $finish;
    end
  end

  // prints one mismatch line with values in hex
  task automatic showMismatch(input string sig, input logic [127:0] expVal,
                              input logic [127:0] gotVal, input int idx);
    $display("** Error: %s expected 0x%0h got 0x%0h (vector %0d)", sig, expVal, gotVal, idx);
  endtask

  // reads direction, key, input and expected output from each line and skips '#' lines
  task automatic loadVectors();
    int                         fd;
    int                         n;
    string                      line;
    logic [3:0]                 dir;
    logic [`AES_BLOCK_BITS-1:0] key;
    logic [`AES_BLOCK_BITS-1:0] blkIn;
    logic [`AES_BLOCK_BITS-1:0] blkOut;
    fd = $fopen("testbench/aes_testdata.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h", dir, key, blkIn, blkOut);
          if (n == 4) begin
            vecDir.push_back(dir[0]);
            vecKey.push_back(key);
            vecIn.push_back(blkIn);
            vecOut.push_back(blkOut);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one request through to its response transfer
  task automatic runVector(input int idx);
    int   gap;
    int   stall;
    int   latency;
    int   expLatency;
    logic [127:0] heldResp;
    rnd = $random(seed);
    gap = rnd & 7;
    rnd = $random(seed);
    stall = rnd & 7;
    expLatency = vecDir[idx] ? DecLatency : EncLatency;

    // a zero idle gap gives back-to-back requests
    repeat (gap) @(negedge clk);
    reqValid    = 1'b1;
    req.key     = vecKey[idx];
    req.data    = vecIn[idx];
    req.decrypt = vecDir[idx];
    while (reqReady !== 1'b1) @(negedge clk);

    // transfer on the next rising edge and scramble the payload afterwards
    @(negedge clk);
    reqValid    = 1'b0;
    req.key     = ~vecKey[idx];
    req.data    = ~vecIn[idx];
    req.decrypt = ~vecDir[idx];
    if (reqReady !== 1'b0) begin
      handshakeErrors++;
      showMismatch("reqReady", 0, reqReady, idx);
    end

    // count rising edges from the accepting one
    latency = 0;
    while (respValid !== 1'b1) begin
      @(negedge clk);
      latency++;
      if (respValid !== 1'b1 && reqReady !== 1'b0) begin
        handshakeErrors++;
        showMismatch("reqReady", 0, reqReady, idx);
      end
    end
    if (latency != expLatency) begin
      timingErrors++;
      showMismatch("respValid latency", expLatency, latency, idx);
    end
    if (resp !== vecOut[idx]) begin
      valueErrors++;
      showMismatch("resp", vecOut[idx], resp, idx);
    end

    // result must sit still under back-pressure
    heldResp = resp;
    repeat (stall) begin
      @(negedge clk);
      if (respValid !== 1'b1) begin
        handshakeErrors++;
        showMismatch("respValid", 1, respValid, idx);
      end
      if (resp !== heldResp) begin
        valueErrors++;
        showMismatch("resp", heldResp, resp, idx);
      end
      if (reqReady !== 1'b0) begin
        handshakeErrors++;
        showMismatch("reqReady", 0, reqReady, idx);
      end
    end

    // engine goes idle one cycle after the response transfer
    respReady = 1'b1;
    @(negedge clk);
    respReady = 1'b0;
    if (reqReady !== 1'b1) begin
      handshakeErrors++;
      showMismatch("reqReady", 1, reqReady, idx);
    end
    if (respValid !== 1'b0) begin
      handshakeErrors++;
      showMismatch("respValid", 0, respValid, idx);
    end
  endtask

  initial begin
    seed      = 57;
    arstN     = 1'b0;
    reqValid  = 1'b0;
    respReady = 1'b0;
    req       = '0;
    loadVectors();
    if (vecDir.size() == 0) begin
      $display("no test vectors could be read from testbench/aes_testdata.txt");
      $display("TEST FAIL");
      $finish;
    end else begin
      cycleLimit = vecDir.size() * CyclesPerVector + 100;

      // reset for 10 cycles with outputs checked inside and after it
      repeat (5) @(negedge clk);
      if (respValid !== 1'b0) begin
        handshakeErrors++;
        showMismatch("respValid", 0, respValid, -1);
      end
      if (reqReady !== 1'b1) begin
        handshakeErrors++;
        showMismatch("reqReady", 1, reqReady, -1);
      end
      repeat (5) @(negedge clk);
      arstN = 1'b1;
      @(negedge clk);
      if (respValid !== 1'b0) begin
        handshakeErrors++;
        showMismatch("respValid", 0, respValid, -1);
      end
      if (reqReady !== 1'b1) begin
        handshakeErrors++;
        showMismatch("reqReady", 1, reqReady, -1);
      end

      for (int i = 0; i < vecDir.size(); i++) begin
        runVector(i);
      end

      $display("errors: value %0d, latency %0d, handshake %0d (%0d vectors)",
               valueErrors, timingErrors, handshakeErrors, vecDir.size());
      if (valueErrors + timingErrors + handshakeErrors == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

endmodule

/* testbench/aes_testdata.txt */
# columns: dir (0 encrypt, 1 decrypt), key, input block, expected output block
# all hex, byte 0 of each block leftmost
0 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
1 2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734
0 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
1 000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
0 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
1 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 00000000000000000000000000000000
0 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
1 00000000000000000000000000000000 0336763e966d92595a567cc9ce537f5e f34481ec3cc627bacd5dc3fb08f273e6
0 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
1 2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a
0 00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
1 2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf ae2d8a571e03ac9c9eb76fac45af8e51
0 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
1 00000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34 80000000000000000000000000000000
0 2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
1 2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688 30c81c46a35ce411e5fbc1191a0a52ef
0 00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34
1 2b7e151628aed2a6abf7158809cf4f3c 7b0c785e27e8ad3f8223207104725dd4 f69f2445df4f9b17ad2b417be66c3710
